/* tb.f */
+incdir+design
design/ebus_pkg.sv
design/io_pkg.sv
design/bus_cycle_fsm.sv
design/baud_timer.sv
design/mem_mapper.sv
design/io_regs.sv
design/esp_tx.sv
design/ebus_top.sv
bench/tb_ebus.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ebus
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/tb_ebus.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module tb_ebus import io_pkg::*; ();

    localparam int BAUD_DIV      = `EBUS_BAUD_DIV;
    localparam int STROBE_CYCLES = 6;
    localparam int IDLE_CYCLES   = 4;
    localparam int CYCLE_LEN     = STROBE_CYCLES + IDLE_CYCLES;
    localparam int BANK_WRITES   = 40;
    localparam int MEM_ACCESSES  = 200;
    localparam int LATCH_ROUNDS  = 16;
    // Every bus cycle of the run, plus the two serial tests in bit times
    localparam int CYCLE_LIMIT   = 8 + CYCLE_LEN * (4 + 2 * BANK_WRITES + MEM_ACCESSES
                                   + 3 * LATCH_ROUNDS + 6) + 30 * BAUD_DIV + 500;

    logic        sysclk;
    logic        reset;
    logic [15:0] a;
    logic [7:0]  data_in;
    logic        rd_n, wr_n, mreq_n, iorq_n;
    logic        cassette_in, printer_in;
    logic [7:0]  data_out;
    logic        data_oe, rom_ce_n, ram_ce_n;
    logic [4:0]  ba;
    logic        cassette_out, printer_out, uart_txd;

    // Reference model
    logic [7:0]  model_bank [4];
    logic        model_cassette, model_printer;

    logic [31:0] lfsr;
    int          error_count, errors_before, tests_run, tests_failed, cycle_count;
    logic [31:0] rnd;
    logic [7:0]  rd_val, port, bank_val, tx_byte, second_byte;
    logic [9:0]  frame;
    logic        rd_oe, is_write, in_sysram, in_hole, mem_ok, found, line_ok;
    logic        exp_rom_n, exp_ram_n, got_rom_n, got_ram_n;
    logic [4:0]  exp_ba, got_ba;
    logic [15:0] addr;
    int          i, bit_idx, low_count;

    ebus_top ebus_top_i (
        .sysclk(sysclk), .reset(reset), .a(a), .data_in(data_in),
        .rd_n(rd_n), .wr_n(wr_n), .mreq_n(mreq_n), .iorq_n(iorq_n),
        .cassette_in(cassette_in), .printer_in(printer_in),
        .data_out(data_out), .data_oe(data_oe),
        .rom_ce_n(rom_ce_n), .ram_ce_n(ram_ce_n), .ba(ba),
        .cassette_out(cassette_out), .printer_out(printer_out),
        .uart_txd(uart_txd));

    always #10 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycle_count++;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, a test never finished", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // Random numbers
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        int k;
        value = '0;
        for (k = 0; k < n; k++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};  // One step per bit
        end
    endtask

    //////////////////////////////
    // Reporting
    //////////////////////////////
    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        error_count++;
        $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, expected, actual);
    endtask

    task automatic report_failure(input string text);
        error_count++;
        $display("%s", text);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count != errors_before) tests_failed++;
        $display("test %-13s %s, %0d errors", name,
                 (error_count == errors_before) ? "ok" : "failed", error_count - errors_before);
        errors_before = error_count;
    endtask

    //////////////////////////////
    // CPU bus cycles
    //////////////////////////////

    // Entered and left on a falling edge
    task automatic io_write(input logic [7:0] p, input logic [7:0] value);
        a       = {8'h00, p};
        data_in = value;
        iorq_n  = 1'b0;
        wr_n    = 1'b0;
        repeat (STROBE_CYCLES) @(negedge sysclk);
        iorq_n  = 1'b1;
        wr_n    = 1'b1;
        repeat (IDLE_CYCLES) @(negedge sysclk);
    endtask

    task automatic io_read(input logic [7:0] p, output logic [7:0] value, output logic oe);
        a      = {8'h00, p};
        iorq_n = 1'b0;
        rd_n   = 1'b0;
        repeat (STROBE_CYCLES) @(negedge sysclk);
        value  = data_out;  // Sampled late in the strobe
        oe     = data_oe;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        repeat (IDLE_CYCLES) @(negedge sysclk);
    endtask

    task automatic mem_access(input logic [15:0] adr, input logic wr,
                              output logic rom_n, output logic ram_n, output logic [4:0] bank_a);
        a      = adr;
        mreq_n = 1'b0;
        rd_n   = wr;
        wr_n   = !wr;
        repeat (STROBE_CYCLES) @(negedge sysclk);
        rom_n  = rom_ce_n;
        ram_n  = ram_ce_n;
        bank_a = ba;
        mreq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        repeat (IDLE_CYCLES) @(negedge sysclk);
    endtask

    task automatic wait_line_low(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < limit) begin
            @(negedge sysclk);
            n++;
            if (uart_txd === 1'b0) seen = 1'b1;
        end
    endtask

    task automatic check_line_idle(input string test, input int cycles);
        logic ok;
        ok = 1'b1;
        repeat (cycles) begin
            @(negedge sysclk);
            if (uart_txd !== 1'b1) ok = 1'b0;
        end
        if (!ok) report_failure({test, ": uart_txd went low while the line should idle"});
    endtask

    initial begin
        sysclk = 1'b0;
        reset = 1'b1;
        a = '0;
        data_in = '0;
        rd_n = 1'b1;
        wr_n = 1'b1;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        cassette_in = 1'b0;
        printer_in = 1'b0;
        lfsr = 32'hd148289e;
        error_count = 0;
        errors_before = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_count = 0;
        model_bank[0] = `EBUS_BANK0_INIT;
        model_bank[1] = `EBUS_BANK1_INIT;
        model_bank[2] = `EBUS_BANK2_INIT;
        model_bank[3] = `EBUS_BANK3_INIT;
        model_cassette = 1'b0;
        model_printer = 1'b0;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        // Idle outputs straight after reset, then the bank defaults
        if (data_oe !== 1'b0) report_mismatch("reset_values", "data_oe", 0, data_oe);
        if (uart_txd !== 1'b1) report_mismatch("reset_values", "uart_txd", 1, uart_txd);
        if (cassette_out !== 1'b0)
            report_mismatch("reset_values", "cassette_out", 0, cassette_out);
        if (printer_out !== 1'b0) report_mismatch("reset_values", "printer_out", 0, printer_out);
        for (i = 0; i < 4; i++) begin
            io_read(8'hF0 + i[7:0], rd_val, rd_oe);
            if (rd_val !== model_bank[i])
                report_mismatch("reset_values", $sformatf("bank%0d", i), model_bank[i], rd_val);
            if (rd_oe !== 1'b1) report_mismatch("reset_values", "data_oe", 1, rd_oe);
        end
        finish_test("reset_values");

        for (i = 0; i < BANK_WRITES; i++) begin
            take_bits(10, rnd);
            port = PORT_BANK0 + rnd[9:8];
            io_write(port, rnd[7:0]);
            model_bank[rnd[9:8]] = rnd[7:0];
            io_read(port, rd_val, rd_oe);
            if (rd_val !== model_bank[rnd[9:8]])
                report_mismatch("bank_rw", $sformatf("port %h", port),
                                model_bank[rnd[9:8]], rd_val);
        end
        finish_test("bank_rw");

        for (i = 0; i < MEM_ACCESSES; i++) begin
            take_bits(17, rnd);
            addr      = rnd[15:0];
            is_write  = rnd[16];
            bank_val  = model_bank[addr[15:14]];
            in_sysram = bank_val[6] && (addr[13:11] == 3'b111);
            in_hole   = bank_val[6] && (addr[13:11] == 3'b110);  // $3000 window stays unmapped
            mem_ok    = !in_sysram && !in_hole && !(is_write && bank_val[7]);
            exp_rom_n = !(mem_ok && bank_val[5:0] <= 6'd15);
            exp_ram_n = !(in_sysram || (mem_ok && bank_val[5:0] >= 6'd32));
            exp_ba    = in_sysram ? 5'd0 : bank_val[4:0];
            mem_access(addr, is_write, got_rom_n, got_ram_n, got_ba);
            if (got_rom_n !== exp_rom_n)
                report_mismatch("mem_decode", $sformatf("rom_ce_n at %h", addr),
                                exp_rom_n, got_rom_n);
            if (got_ram_n !== exp_ram_n)
                report_mismatch("mem_decode", $sformatf("ram_ce_n at %h", addr),
                                exp_ram_n, got_ram_n);
            if (got_ba !== exp_ba)
                report_mismatch("mem_decode", $sformatf("ba at %h", addr), exp_ba, got_ba);
        end
        finish_test("mem_decode");

        for (i = 0; i < LATCH_ROUNDS; i++) begin
            take_bits(11, rnd);
            cassette_in = rnd[10];
            printer_in  = rnd[9];
            port = rnd[8] ? PORT_PRINTER : PORT_CASSETTE;
            io_write(port, rnd[7:0]);
            if (rnd[8]) model_printer = rnd[0];
            else model_cassette = rnd[0];
            if (cassette_out !== model_cassette)
                report_mismatch("out_latches", "cassette_out", model_cassette, cassette_out);
            if (printer_out !== model_printer)
                report_mismatch("out_latches", "printer_out", model_printer, printer_out);
            io_read(PORT_CASSETTE, rd_val, rd_oe);
            if (rd_val !== {7'b0, cassette_in})
                report_mismatch("out_latches", "cassette read", {7'b0, cassette_in}, rd_val);
            io_read(PORT_PRINTER, rd_val, rd_oe);
            if (rd_val !== {7'b0, printer_in})
                report_mismatch("out_latches", "printer read", {7'b0, printer_in}, rd_val);
        end
        finish_test("out_latches");

        //////////////////////////////
        // Serial link
        //////////////////////////////
        take_bits(16, rnd);
        tx_byte     = rnd[7:0];
        second_byte = rnd[15:8];
        frame       = {1'b1, tx_byte, 1'b0};  // Stop, data LSB first, start
        fork
            begin
                io_write(PORT_ESPDATA, tx_byte);
                io_read(PORT_ESPCTRL, rd_val, rd_oe);
                if (rd_val[1] !== 1'b1) report_mismatch("serial_frame", "busy", 1, rd_val[1]);
                io_write(PORT_ESPDATA, second_byte);  // Must be dropped
            end
            begin
                wait_line_low(2 * CYCLE_LEN, found);
                if (!found) begin
                    report_failure("serial_frame: uart_txd never dropped for a start bit");
                end else begin
                    repeat (BAUD_DIV / 2) @(negedge sysclk);
                    for (bit_idx = 0; bit_idx < 10; bit_idx++) begin
                        if (uart_txd !== frame[bit_idx])
                            report_mismatch("serial_frame", $sformatf("bit %0d", bit_idx),
                                            frame[bit_idx], uart_txd);
                        if (bit_idx < 9) repeat (BAUD_DIV) @(negedge sysclk);
                    end
                end
            end
        join
        check_line_idle("serial_frame", 3 * BAUD_DIV);
        io_read(PORT_ESPCTRL, rd_val, rd_oe);
        if (rd_val[1] !== 1'b0) report_mismatch("serial_frame", "busy after frame", 0, rd_val[1]);
        finish_test("serial_frame");

        fork
            io_write(PORT_ESPCTRL, 8'h80);
            begin
                wait_line_low(2 * CYCLE_LEN, found);
                if (!found) begin
                    report_failure("break: uart_txd never went low after the break request");
                end else begin
                    low_count = 1;
                    line_ok   = 1'b0;
                    while (!line_ok && low_count <= 12 * BAUD_DIV) begin
                        @(negedge sysclk);
                        if (uart_txd === 1'b0) low_count++;
                        else line_ok = 1'b1;
                    end
                    if (low_count < 10 * BAUD_DIV - 1 || low_count > 10 * BAUD_DIV + 1)
                        report_mismatch("break", "low cycles", 10 * BAUD_DIV, low_count);
                end
            end
        join
        check_line_idle("break", 2 * BAUD_DIV);
        finish_test("break");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* design/ebus_top.sv */
`timescale 1ns/1ps

module ebus_top import ebus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [15:0] a,
    input  logic [7:0]  data_in,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        cassette_in,
    input  logic        printer_in,
    output logic [7:0]  data_out,
    output logic        data_oe,
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output logic [4:0]  ba,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        uart_txd
);

    logic       bus_write;
    logic [7:0] wrdata;
    logic       io_hit;
    bank_reg_t  bank0, bank1, bank2, bank3;
    logic       tx_start, tx_break, tx_busy;
    logic [7:0] tx_data;
    logic       baud_en, bit_tick;

    //////////////////////////////
    // Bus side
    //////////////////////////////

    // No port has read side effects yet
    bus_cycle_fsm bus_cycle_fsm_i (
        .sysclk(sysclk),
        .reset(reset),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .data_in(data_in),
        .bus_read(),
        .bus_write(bus_write),
        .wrdata(wrdata));

    mem_mapper mem_mapper_i (
        .a(a), .mreq_n(mreq_n), .wr_n(wr_n), .io_hit(io_hit),
        .bank0(bank0), .bank1(bank1), .bank2(bank2), .bank3(bank3),
        .rom_ce_n(rom_ce_n), .ram_ce_n(ram_ce_n), .ba(ba));

    io_regs io_regs_i (
        .sysclk(sysclk), .reset(reset), .a(a), .iorq_n(iorq_n), .rd_n(rd_n),
        .bus_write(bus_write), .wrdata(wrdata), .tx_busy(tx_busy),
        .cassette_in(cassette_in), .printer_in(printer_in),
        .bank0(bank0), .bank1(bank1), .bank2(bank2), .bank3(bank3),
        .io_hit(io_hit), .data_out(data_out), .data_oe(data_oe),
        .cassette_out(cassette_out), .printer_out(printer_out),
        .tx_start(tx_start), .tx_data(tx_data), .tx_break(tx_break));

    //////////////////////////////
    // Serial link to the ESP32
    //////////////////////////////
    esp_tx esp_tx_i (
        .sysclk(sysclk), .reset(reset),
        .tx_start(tx_start), .tx_data(tx_data), .tx_break(tx_break),
        .bit_tick(bit_tick), .baud_en(baud_en), .tx_busy(tx_busy),
        .uart_txd(uart_txd));

    baud_timer baud_timer_i (
        .sysclk(sysclk), .reset(reset),
        .baud_en(baud_en), .bit_tick(bit_tick));

endmodule

/* design/esp_tx.sv */
`timescale 1ns/1ps

module esp_tx import io_pkg::*; (
    input  logic       sysclk,
    input  logic       reset,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    input  logic       tx_break,
    input  logic       bit_tick,
    output logic       baud_en,
    output logic       tx_busy,
    output logic       uart_txd
);

    tx_state_e  state;
    logic [9:0] shreg;      // Stop, data, start
    logic [3:0] bit_cnt;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            state   <= TX_IDLE;
            bit_cnt <= 4'd0;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_cnt <= 4'd0;
                    if (tx_break)
                        state <= TX_BREAK;  // Break wins
                    else if (tx_start)
                        state <= TX_SHIFT;
                end
                TX_SHIFT, TX_BREAK: begin
                    if (bit_tick) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd9) state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // LSB first with ones shifted in behind
    always_ff @(posedge sysclk) begin
        if (state == TX_IDLE && tx_start)
            shreg <= {1'b1, tx_data, 1'b0};
        else if (state == TX_SHIFT && bit_tick)
            shreg <= {1'b1, shreg[9:1]};
    end

    assign tx_busy  = (state != TX_IDLE);
    assign baud_en  = tx_busy;
    assign uart_txd = (state == TX_SHIFT) ? shreg[0] : (state != TX_BREAK);

    // The stop bit loaded ten bits ago reaches the line high
    a_line_high : assert property (@(posedge sysclk) disable iff (reset)
        (state == TX_SHIFT && bit_cnt == 4'd9) |-> uart_txd);

endmodule

/* design/io_regs.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module io_regs import ebus_pkg::*, io_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [15:0] a,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        bus_write,
    input  logic [7:0]  wrdata,
    input  logic        tx_busy,
    input  logic        cassette_in,
    input  logic        printer_in,
    output bank_reg_t   bank0,
    output bank_reg_t   bank1,
    output bank_reg_t   bank2,
    output bank_reg_t   bank3,
    output logic        io_hit,
    output logic [7:0]  data_out,
    output logic        data_oe,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        tx_start,
    output logic [7:0]  tx_data,
    output logic        tx_break
);

    logic sel_bank0, sel_bank1, sel_bank2, sel_bank3;
    logic sel_espctrl, sel_espdata;
    logic sel_cassette, sel_cpm, sel_printer;

    //////////////////////////////
    // Port decode
    //////////////////////////////
    assign sel_bank0    = !iorq_n && (a[7:0] == PORT_BANK0);
    assign sel_bank1    = !iorq_n && (a[7:0] == PORT_BANK1);
    assign sel_bank2    = !iorq_n && (a[7:0] == PORT_BANK2);
    assign sel_bank3    = !iorq_n && (a[7:0] == PORT_BANK3);
    assign sel_espctrl  = !iorq_n && (a[7:0] == PORT_ESPCTRL);
    assign sel_espdata  = !iorq_n && (a[7:0] == PORT_ESPDATA);
    assign sel_cassette = !iorq_n && (a[7:0] == PORT_CASSETTE);
    assign sel_cpm      = !iorq_n && (a[7:0] == PORT_CPM);
    assign sel_printer  = !iorq_n && (a[7:0] == PORT_PRINTER);

    assign io_hit = sel_bank0 | sel_bank1 | sel_bank2 | sel_bank3 |
                    sel_espctrl | sel_espdata |
                    sel_cassette | sel_cpm | sel_printer;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank0        <= bank_reg_t'(`EBUS_BANK0_INIT);
            bank1        <= bank_reg_t'(`EBUS_BANK1_INIT);
            bank2        <= bank_reg_t'(`EBUS_BANK2_INIT);
            bank3        <= bank_reg_t'(`EBUS_BANK3_INIT);
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (bus_write) begin
            if (sel_bank0)    bank0        <= bank_reg_t'(wrdata);
            if (sel_bank1)    bank1        <= bank_reg_t'(wrdata);
            if (sel_bank2)    bank2        <= bank_reg_t'(wrdata);
            if (sel_bank3)    bank3        <= bank_reg_t'(wrdata);
            if (sel_cassette) cassette_out <= wrdata[0];
            if (sel_printer)  printer_out  <= wrdata[0];
        end
    end

    // Transmitter requests with data dropped while busy
    assign tx_start = sel_espdata && bus_write && !tx_busy;
    assign tx_data  = wrdata;
    assign tx_break = sel_espctrl && bus_write && wrdata[ESPCTRL_BREAK_BIT];

    //////////////////////////////
    // Read back
    //////////////////////////////
    always_comb begin
        data_out = 8'h00;
        if (sel_bank0)    data_out = bank0;
        if (sel_bank1)    data_out = bank1;
        if (sel_bank2)    data_out = bank2;
        if (sel_bank3)    data_out = bank3;
        if (sel_espctrl)  data_out[ESPCTRL_BUSY_BIT] = tx_busy;
        if (sel_cassette) data_out = {7'b0, cassette_in};
        if (sel_printer)  data_out = {7'b0, printer_in};
    end

    // ESPDATA and CPM read as zero
    assign data_oe = !rd_n && io_hit;

    // Accepted byte must show up as busy in the status
    a_start_busy : assert property (@(posedge sysclk) disable iff (reset)
        tx_start |=> tx_busy);

endmodule

/* design/mem_mapper.sv */
`timescale 1ns/1ps

module mem_mapper import ebus_pkg::*; (
    input  logic [15:0] a,
    input  logic        mreq_n,
    input  logic        wr_n,
    input  logic        io_hit,
    input  bank_reg_t   bank0,
    input  bank_reg_t   bank1,
    input  bank_reg_t   bank2,
    input  bank_reg_t   bank3,
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output logic [4:0]  ba
);

    bank_reg_t  bank;
    page_kind_e kind;
    logic       win_sysram;
    logic       win_hole;
    logic       allow_mem;
    logic       sel_sysram;

    // Bank register for the addressed quarter
    always_comb begin
        case (a[15:14])
            2'd0:    bank = bank0;
            2'd1:    bank = bank1;
            2'd2:    bank = bank2;
            default: bank = bank3;
        endcase
    end

    always_comb begin
        if (bank.page <= PAGE_ROM_LAST)
            kind = PAGE_ROM;
        else if (bank.page >= PAGE_CART_FIRST && bank.page <= PAGE_CART_LAST)
            kind = PAGE_CART;
        else if (bank.page >= PAGE_RAM_FIRST)
            kind = PAGE_RAM;
        else
            kind = PAGE_NONE;
    end

    //////////////////////////////
    // Overlay windows
    //////////////////////////////
    assign win_sysram = bank.overlay && (a[13:11] == 3'b111);  // $3800-$3FFF
    assign win_hole   = bank.overlay && (a[13:11] == 3'b110);  // $3000-$37FF, unmapped

    assign sel_sysram = !mreq_n && !io_hit && win_sysram;

    // Writes to read-only banks reach no chip
    assign allow_mem = !mreq_n && !io_hit && !win_sysram && !win_hole &&
                       (wr_n || !bank.read_only);

    // Cartridge pages decode but have no enable here
    assign rom_ce_n = !(allow_mem && kind == PAGE_ROM);
    assign ram_ce_n = !((allow_mem && kind == PAGE_RAM) || sel_sysram);

    assign ba = win_sysram ? 5'd0 : bank.page[4:0];  // System RAM is page 32

endmodule

/* design/baud_timer.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module baud_timer (
    input  logic sysclk,
    input  logic reset,
    input  logic baud_en,
    output logic bit_tick
);

    localparam int DIV = `EBUS_BAUD_DIV;
    localparam int CW  = $clog2(DIV);

    logic [CW-1:0] count;

    assign bit_tick = baud_en && (count == CW'(DIV - 1));

    // Restarts on every enable so the first tick is a full bit away
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset)
            count <= '0;
        else if (!baud_en || bit_tick)
            count <= '0;
        else
            count <= count + 1'b1;
    end

endmodule

/* design/bus_cycle_fsm.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module bus_cycle_fsm (
    input  logic       sysclk,
    input  logic       reset,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic [7:0] data_in,
    output logic       bus_read,
    output logic       bus_write,
    output logic [7:0] wrdata
);

    localparam int SYNC_DEPTH = `EBUS_SYNC_DEPTH;

    typedef enum logic [1:0] {
        CYC_IDLE,
        CYC_READ,
        CYC_WRITE,
        CYC_HOLD
    } cyc_state_e;

    cyc_state_e            state;
    logic [SYNC_DEPTH-1:0] rd_sync;
    logic [SYNC_DEPTH-1:0] wr_sync;
    logic                  rd_low;
    logic                  wr_low;

    // Strobes come from the CPU clock domain
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_sync <= '1;
            wr_sync <= '1;
        end else begin
            rd_sync <= {rd_sync[SYNC_DEPTH-2:0], rd_n};
            wr_sync <= {wr_sync[SYNC_DEPTH-2:0], wr_n};
        end
    end

    assign rd_low = !rd_sync[SYNC_DEPTH-1];
    assign wr_low = !wr_sync[SYNC_DEPTH-1];

    // One pulse per bus cycle and HOLD until the strobes release
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            state <= CYC_IDLE;
        end else begin
            case (state)
                CYC_IDLE: begin
                    if (wr_low)
                        state <= CYC_WRITE;
                    else if (rd_low)
                        state <= CYC_READ;
                end
                CYC_READ, CYC_WRITE: state <= CYC_HOLD;
                default: if (!rd_low && !wr_low) state <= CYC_IDLE;
            endcase
        end
    end

    assign bus_read  = (state == CYC_READ);
    assign bus_write = (state == CYC_WRITE);

    // Write data settles long before bus_write
    always_ff @(posedge sysclk) begin
        if (!wr_n) wrdata <= data_in;
    end

    // A read and a write strobe together would lose the read
    a_one_strobe : assert property (@(posedge sysclk) disable iff (reset)
        !(rd_low && wr_low));

endmodule

/* design/io_pkg.sv */
package io_pkg;

    // Decoded IO ports, compared against a[7:0]
    typedef enum logic [7:0] {
        PORT_BANK0    = 8'hF0,
        PORT_BANK1    = 8'hF1,
        PORT_BANK2    = 8'hF2,
        PORT_BANK3    = 8'hF3,
        PORT_ESPCTRL  = 8'hF4,
        PORT_ESPDATA  = 8'hF5,
        PORT_CASSETTE = 8'hFC,
        PORT_CPM      = 8'hFD,  // Write only
        PORT_PRINTER  = 8'hFE
    } io_port_e;

    // ESPCTRL bit positions
    localparam int ESPCTRL_BREAK_BIT = 7;  // Write
    localparam int ESPCTRL_BUSY_BIT  = 1;  // Read

    // Serial transmitter states
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_SHIFT = 2'd1,
        TX_BREAK = 2'd2
    } tx_state_e;

endpackage

/* design/ebus_pkg.sv */
package ebus_pkg;

    // 16 KB page number, 64 pages in total
    typedef logic [5:0] page_t;

    // Bank register layout, one per CPU quarter
    typedef struct packed {
        logic  read_only;   // Bit 7
        logic  overlay;     // Bit 6, enables the $3000-$3FFF windows
        page_t page;        // Bits 5:0
    } bank_reg_t;

    //////////////////////////////
    // Page ranges
    //////////////////////////////
    localparam page_t PAGE_ROM_LAST   = 6'd15;  // Flash 256 KB
    localparam page_t PAGE_CART_FIRST = 6'd16;
    localparam page_t PAGE_CART_LAST  = 6'd19;
    localparam page_t PAGE_RAM_FIRST  = 6'd32;  // RAM 512 KB

    // What a page maps to
    typedef enum logic [1:0] {
        PAGE_NONE = 2'd0,
        PAGE_ROM  = 2'd1,
        PAGE_CART = 2'd2,
        PAGE_RAM  = 2'd3
    } page_kind_e;

endpackage

/* design/ebus_settings.svh */
`ifndef EBUS_SETTINGS_SVH
`define EBUS_SETTINGS_SVH

// Serial timing
`define EBUS_BAUD_DIV    16     // sysclk cycles per bit

// Strobe synchronizer
`define EBUS_SYNC_DEPTH  2

//////////////////////////////
// Bank register reset values
//////////////////////////////

// ROM page 0, read only, overlay enabled
`define EBUS_BANK0_INIT  8'hC0
`define EBUS_BANK1_INIT  8'h21  // RAM page 33
`define EBUS_BANK2_INIT  8'h22  // RAM page 34
`define EBUS_BANK3_INIT  8'h13  // Page 19

`endif
